//--- src/zap_shift_pkg.sv
/*
 * Operand stage shared definitions: register file constants, shift and
 * condition encodings, and the issue source word with its two decodings.
 */
package zap_shift_pkg;

        //////////////////////////////////////////////////
        // Register file and datapath sizes.
        //////////////////////////////////////////////////

        localparam int PHY_REGS_DEF = 46;
        localparam int SRC_IDX_W    = $clog2(PHY_REGS_DEF);
        localparam int PHY_PC       = 15;
        localparam int WORD_W       = 32;
        localparam int SRC_W        = WORD_W + 1;

        // Never executes. Marks an empty slot in the pipeline.
        localparam logic [3:0] COND_NV = 4'b1111;

        //////////////////////////////////////////////////
        // Encodings.
        //////////////////////////////////////////////////

        typedef enum logic [2:0] {
                LSL = 3'd0,
                LSR = 3'd1,
                ASR = 3'd2,
                ROR = 3'd3,
                RRX = 3'd4
        } shift_op_t;

        // Source word seen as an immediate.
        typedef struct packed {
                logic              en;
                logic [WORD_W-1:0] value;
        } src_imm_t;

        // Same word seen as a register index.
        typedef struct packed {
                logic                        en;
                logic [WORD_W-SRC_IDX_W-1:0] pad;
                logic [SRC_IDX_W-1:0]        index;
        } src_reg_t;

        // Top bit set means immediate, otherwise a register index.
        typedef union packed {
                src_imm_t imm_view;
                src_reg_t reg_view;
        } src_word_t;

endpackage

//--- src/zap_barrel_shifter.sv
/*
 * Barrel shifter. LSL, LSR, ASR, ROR and RRX with carry out,
 * following the boundary behavior for amounts of 0, 32 and beyond.
 */
module zap_barrel_shifter
        import zap_shift_pkg::*;
(
        input  logic              i_clk,
        input  logic [WORD_W-1:0] i_source,
        input  logic [7:0]        i_amount,
        input  shift_op_t         i_shift_type,
        input  logic              i_carry,
        output logic [WORD_W-1:0] o_result,
        output logic              o_carry
);

//////////////////////////////////////////////////

logic [4:0]          amt_lo;
logic [WORD_W:0]     lsl_ext;
logic [WORD_W:0]     lsr_ext;
logic [WORD_W:0]     asr_ext;
logic [2*WORD_W-1:0] ror_ext;

//////////////////////////////////////////////////
// Partial shifts for amounts below 32.
//////////////////////////////////////////////////

assign amt_lo = i_amount[4:0];

// Extra bit above the word catches the last bit shifted out.
assign lsl_ext = {1'b0, i_source} << amt_lo;

// Extra bit below the word catches the last bit shifted out.
assign lsr_ext = {i_source, 1'b0} >> amt_lo;
assign asr_ext = $signed({i_source, 1'b0}) >>> amt_lo;

// Doubled word so a plain right shift gives the rotation.
assign ror_ext = {i_source, i_source} >> amt_lo;

//////////////////////////////////////////////////
// Result and carry selection.
//////////////////////////////////////////////////

always_comb
begin
        o_result = i_source;
        o_carry  = i_carry;

        if (i_shift_type == RRX)
        begin
                // Carry rotates in at the top, bit 0 falls out.
                o_result = {i_carry, i_source[WORD_W-1:1]};
                o_carry  = i_source[0];
        end
        else if (i_amount != 8'd0)
        begin
                case (i_shift_type)
                LSL:
                begin
                        if (i_amount < 8'd32)
                        begin
                                o_result = lsl_ext[WORD_W-1:0];
                                o_carry  = lsl_ext[WORD_W];
                        end
                        else
                        begin
                                o_result = '0;
                                o_carry  = (i_amount == 8'd32) ? i_source[0] : 1'b0;
                        end
                end

                LSR:
                begin
                        if (i_amount < 8'd32)
                        begin
                                o_result = lsr_ext[WORD_W:1];
                                o_carry  = lsr_ext[0];
                        end
                        else
                        begin
                                o_result = '0;
                                o_carry  = (i_amount == 8'd32) ? i_source[WORD_W-1] : 1'b0;
                        end
                end

                ASR:
                begin
                        if (i_amount < 8'd32)
                        begin
                                o_result = asr_ext[WORD_W:1];
                                o_carry  = asr_ext[0];
                        end
                        else
                        begin
                                // Sign fills the whole word.
                                o_result = {WORD_W{i_source[WORD_W-1]}};
                                o_carry  = i_source[WORD_W-1];
                        end
                end

                ROR:
                begin
                        // Whole turns return the word with its top bit as carry.
                        o_result = ror_ext[WORD_W-1:0];
                        o_carry  = ror_ext[WORD_W-1];
                end

                default:
                begin
                        o_result = i_source;
                        o_carry  = i_carry;
                end
                endcase
        end
end

//////////////////////////////////////////////////

// Issue only sends the five defined shift codes.
a_shift_type_legal : assert property (
        @(posedge i_clk)
        !$isunknown(i_shift_type) |-> (i_shift_type inside {LSL, LSR, ASR, ROR, RRX})
);

endmodule

//--- src/zap_operand_resolver.sv
/*
 * Operand restoration. Replaces a speculatively read value with an
 * immediate, the PC+8 or the ALU result that is being produced now.
 */
module zap_operand_resolver
        import zap_shift_pkg::*;
#(
        parameter int PHY_REGS = PHY_REGS_DEF,
        parameter bit ALIGN    = 1'b0
)
(
        input  src_word_t               i_source,
        input  logic [WORD_W-1:0]       i_issue_value,
        input  logic [WORD_W-1:0]       i_pc_plus_8,
        input  logic [$clog2(PHY_REGS)-1:0] i_stage_dest_index,
        input  logic [WORD_W-1:0]       i_alu_value_nxt,
        input  logic                    i_alu_dav_nxt,
        input  logic                    i_force_align,
        output logic [WORD_W-1:0]       o_value
);

localparam int IDX_W = $clog2(PHY_REGS);

logic [IDX_W-1:0] src_index;

// Register view of the source word, sized to this register file.
assign src_index = IDX_W'(i_source.reg_view.index);

always_comb
begin
        if (i_source.imm_view.en)
        begin
                o_value = i_source.imm_view.value;
        end
        else if (i_source == SRC_W'(PHY_PC))
        begin
                o_value = i_pc_plus_8;
        end
        else if (i_alu_dav_nxt && (src_index == i_stage_dest_index))
        begin
                // Result sitting in the ALU is newer than the file.
                o_value = i_alu_value_nxt;
        end
        else
        begin
                o_value = i_issue_value;
        end

        // Word alignment of a PC based source.
        if (ALIGN && i_force_align)
        begin
                o_value[1:0] = 2'b00;
        end
end

endmodule

//--- src/zap_shift_stage_regs.sv
/*
 * Operand stage register. Picks the shifted or restored operand and
 * its carry, then holds the stage under clear and stall control.
 */
module zap_shift_stage_regs
        import zap_shift_pkg::*;
#(
        parameter int PHY_REGS = PHY_REGS_DEF
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,
        input  logic                        i_clear_from_writeback,
        input  logic                        i_data_stall,
        input  logic                        i_clear_from_alu,
        input  logic                        i_disable_shifter,
        input  logic [WORD_W-1:0]           i_shift_result,
        input  logic                        i_shift_carry,
        input  logic                        i_carry_nxt,
        input  logic [WORD_W-1:0]           i_alu_value,
        input  logic [WORD_W-1:0]           i_shift_value,
        input  logic [3:0]                  i_condition_code,
        input  logic [$clog2(PHY_REGS)-1:0] i_destination_index,
        input  logic [WORD_W-1:0]           i_pc_plus_8,
        output logic [3:0]                  o_condition_code,
        output logic [$clog2(PHY_REGS)-1:0] o_destination_index,
        output logic [WORD_W-1:0]           o_alu_source_value,
        output logic [WORD_W-1:0]           o_shifted_source_value,
        output logic                        o_shift_carry,
        output logic [WORD_W-1:0]           o_pc_plus_8
);

logic [WORD_W-1:0] shifted_nxt;
logic              carry_nxt;

//////////////////////////////////////////////////
// Operand and carry selection.
//////////////////////////////////////////////////

// With the shifter off the restored value passes straight through.
assign shifted_nxt = i_disable_shifter ? i_shift_value : i_shift_result;
assign carry_nxt   = i_disable_shifter ? i_carry_nxt   : i_shift_carry;

//////////////////////////////////////////////////
// Stage flops.
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_condition_code       <= COND_NV;
                o_destination_index    <= '0;
                o_alu_source_value     <= '0;
                o_shifted_source_value <= '0;
                o_shift_carry          <= 1'b0;
                o_pc_plus_8            <= '0;
        end
        else if (i_clear_from_writeback)
        begin
                // Kill the slot, payload is left as is.
                o_condition_code <= COND_NV;
        end
        else if (i_data_stall)
        begin
                // Hold everything
        end
        else if (i_clear_from_alu)
        begin
                o_condition_code <= COND_NV;
        end
        else
        begin
                o_condition_code       <= i_condition_code;
                o_destination_index    <= i_destination_index;
                o_alu_source_value     <= i_alu_value;
                o_shifted_source_value <= shifted_nxt;
                o_shift_carry          <= carry_nxt;
                o_pc_plus_8            <= i_pc_plus_8;
        end
end

//////////////////////////////////////////////////

a_reset_empty : assert property (
        @(posedge i_clk) i_reset |=> (o_condition_code == COND_NV)
);

// A stall freezes the stage unless writeback flushes it.
a_stall_holds : assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_data_stall && !i_clear_from_writeback) |=>
                ($stable(o_condition_code) && $stable(o_destination_index) &&
                 $stable(o_alu_source_value) && $stable(o_shifted_source_value) &&
                 $stable(o_shift_carry) && $stable(o_pc_plus_8))
);

endmodule

//--- src/zap_shift_stage.sv
/*
 * Operand stage between issue and ALU. Shifter, two operand
 * resolvers and the stage register.
 */
module zap_shift_stage
        import zap_shift_pkg::*;
#(
        parameter int PHY_REGS = PHY_REGS_DEF
)
(
        input  logic                        i_clk,
        input  logic                        i_reset,

        // Clear and stall, highest priority first.
        input  logic                        i_clear_from_writeback,
        input  logic                        i_data_stall,
        input  logic                        i_clear_from_alu,

        // From issue.
        input  logic [3:0]                  i_condition_code,
        input  logic [$clog2(PHY_REGS)-1:0] i_destination_index,
        input  src_word_t                   i_alu_source,
        input  src_word_t                   i_shift_source,
        input  logic [WORD_W-1:0]           i_alu_source_value,
        input  logic [WORD_W-1:0]           i_shift_source_value,
        input  logic [WORD_W-1:0]           i_shift_length_value,
        input  shift_op_t                   i_shift_type,
        input  logic                        i_disable_shifter,
        input  logic                        i_force_align,
        input  logic [WORD_W-1:0]           i_pc_plus_8,

        // Flags, current and next.
        input  logic                        i_carry,
        input  logic                        i_carry_nxt,

        // ALU feed forward.
        input  logic [WORD_W-1:0]           i_alu_value_nxt,
        input  logic                        i_alu_dav_nxt,

        // To the ALU.
        output logic [3:0]                  o_condition_code,
        output logic [$clog2(PHY_REGS)-1:0] o_destination_index,
        output logic [WORD_W-1:0]           o_alu_source_value,
        output logic [WORD_W-1:0]           o_shifted_source_value,
        output logic                        o_shift_carry,
        output logic [WORD_W-1:0]           o_pc_plus_8
);

logic [WORD_W-1:0] shift_result;
logic              shift_carry;
logic [WORD_W-1:0] alu_value;
logic [WORD_W-1:0] shift_value;

//////////////////////////////////////////////////

zap_barrel_shifter u_shifter (
        .i_clk        (i_clk),
        .i_source     (i_shift_source_value),
        .i_amount     (i_shift_length_value[7:0]),
        .i_shift_type (i_shift_type),
        .i_carry      (i_carry),
        .o_result     (shift_result),
        .o_carry      (shift_carry)
);

// ALU source may be a PC read that needs word alignment.
zap_operand_resolver #(
        .PHY_REGS (PHY_REGS),
        .ALIGN    (1'b1)
) u_alu_res (
        .i_source           (i_alu_source),
        .i_issue_value      (i_alu_source_value),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_stage_dest_index (o_destination_index),
        .i_alu_value_nxt    (i_alu_value_nxt),
        .i_alu_dav_nxt      (i_alu_dav_nxt),
        .i_force_align      (i_force_align),
        .o_value            (alu_value)
);

zap_operand_resolver #(
        .PHY_REGS (PHY_REGS),
        .ALIGN    (1'b0)
) u_shf_res (
        .i_source           (i_shift_source),
        .i_issue_value      (i_shift_source_value),
        .i_pc_plus_8        (i_pc_plus_8),
        .i_stage_dest_index (o_destination_index),
        .i_alu_value_nxt    (i_alu_value_nxt),
        .i_alu_dav_nxt      (i_alu_dav_nxt),
        .i_force_align      (),
        .o_value            (shift_value)
);

//////////////////////////////////////////////////

zap_shift_stage_regs #(
        .PHY_REGS (PHY_REGS)
) u_regs (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_disable_shifter      (i_disable_shifter),
        .i_shift_result         (shift_result),
        .i_shift_carry          (shift_carry),
        .i_carry_nxt            (i_carry_nxt),
        .i_alu_value            (alu_value),
        .i_shift_value          (shift_value),
        .i_condition_code       (i_condition_code),
        .i_destination_index    (i_destination_index),
        .i_pc_plus_8            (i_pc_plus_8),
        .o_condition_code       (o_condition_code),
        .o_destination_index    (o_destination_index),
        .o_alu_source_value     (o_alu_source_value),
        .o_shifted_source_value (o_shifted_source_value),
        .o_shift_carry          (o_shift_carry),
        .o_pc_plus_8            (o_pc_plus_8)
);

endmodule

//--- tests/tb_shift_model.svh
/*
 * Reference model for the operand stage testbench. LFSR stimulus source,
 * shift rules and operand restoration rules.
 */
`ifndef TB_SHIFT_MODEL_SVH
`define TB_SHIFT_MODEL_SVH

logic [31:0] lfsr_state;

// One step of a 32 bit Fibonacci LFSR, taps 32 22 2 1.
function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
endfunction

// Collects n fresh bits, one LFSR step per bit.
function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
                v = {v[30:0], lfsr_step()};
        end
        return v;
endfunction

// Amounts lean on the boundary cases.
function automatic logic [7:0] pick_amount();
        logic [2:0] sel;
        sel = 3'(lfsr_bits(3));
        case (sel)
        3'd0:    return 8'd0;
        3'd1:    return 8'd1;
        3'd2:    return 8'd31;
        3'd3:    return 8'd32;
        3'd4:    return 8'd33;
        3'd5:    return 8'd255;
        default: return 8'(lfsr_bits(8));
        endcase
endfunction

// Returns {carry, result}.
function automatic logic [32:0] shift_ref(input logic [31:0] src, input logic [7:0] amount,
                                          input shift_op_t op, input logic cin);
        logic [31:0] r;
        logic        c;
        int          n;
        int          k;
        r = src;
        c = cin;
        n = amount;
        k = n % 32;
        if (op == RRX)
        begin
                r = {cin, src[31:1]};
                c = src[0];
        end
        else if (n == 0)
        begin
                r = src;
        end
        else if (op == LSL)
        begin
                r = (n < 32) ? (src << n) : 32'd0;
                c = (n < 32) ? src[32 - n] : ((n == 32) ? src[0] : 1'b0);
        end
        else if (op == LSR)
        begin
                r = (n < 32) ? (src >> n) : 32'd0;
                c = (n < 32) ? src[n - 1] : ((n == 32) ? src[31] : 1'b0);
        end
        else if (op == ASR)
        begin
                r = (n < 32) ? 32'($signed(src) >>> n) : {32{src[31]}};
                c = (n < 32) ? src[n - 1] : src[31];
        end
        else if (k == 0)
        begin
                c = src[31];
        end
        else
        begin
                r = (src >> k) | (src << (32 - k));
                c = r[31];
        end
        return {c, r};
endfunction

// Immediate, then PC, then ALU feed forward, then the issue value.
function automatic logic [31:0] resolve_ref(input logic [32:0] word, input logic [31:0] issue,
                                            input logic [31:0] pc8, input logic [IDX_W-1:0] dest,
                                            input logic [31:0] alu, input logic dav);
        if (word[32])
                return word[31:0];
        if (word == 33'(PHY_PC))
                return pc8;
        if (dav && (word[IDX_W-1:0] == dest))
                return alu;
        return issue;
endfunction

`endif

//--- tests/tb_shift_stage.sv
/*
 * Operand stage testbench. Random operands from an LFSR, checked each
 * cycle against a reference model of the stage register.
 */
module tb_shift_stage
        import zap_shift_pkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        localparam int PHY_REGS     = 46;
        localparam int IDX_W        = $clog2(PHY_REGS);
        localparam int RESET_CYCLES = 10;
        localparam int N_SHIFT      = 400;
        localparam int N_RESTORE    = 300;
        localparam int N_ALIGN      = 200;
        localparam int N_CTRL       = 300;
        localparam int TOTAL_CYCLES = RESET_CYCLES + N_SHIFT + N_RESTORE + N_ALIGN + N_CTRL + 4;

        localparam int MODE_SHIFT   = 0;
        localparam int MODE_RESTORE = 1;
        localparam int MODE_ALIGN   = 2;
        localparam int MODE_CTRL    = 3;

        logic clk;
        logic reset;
        logic clear_wb;
        logic stall;
        logic clear_alu;
        logic [3:0] cond_code;
        logic [IDX_W-1:0] dest_index;
        src_word_t alu_src;
        src_word_t shf_src;
        logic [31:0] alu_src_value;
        logic [31:0] shf_src_value;
        logic [31:0] shift_len;
        shift_op_t shift_type;
        logic disable_shifter;
        logic force_align;
        logic [31:0] pc_plus_8;
        logic carry;
        logic carry_nxt;
        logic [31:0] alu_value_nxt;
        logic alu_dav_nxt;

        logic [3:0] dut_cc;
        logic [IDX_W-1:0] dut_dest;
        logic [31:0] dut_alu;
        logic [31:0] dut_shf;
        logic dut_carry;
        logic [31:0] dut_pc8;

        // Expected registered outputs.
        logic [3:0] exp_cc;
        logic [IDX_W-1:0] exp_dest;
        logic [31:0] exp_alu;
        logic [31:0] exp_shf;
        logic exp_carry;
        logic [31:0] exp_pc8;

        int checks;
        int errors;
        int tests;

        `include "tb_shift_model.svh"

        zap_shift_stage #(
                .PHY_REGS (PHY_REGS)
        ) u_dut (
                .i_clk                  (clk),
                .i_reset                (reset),
                .i_clear_from_writeback (clear_wb),
                .i_data_stall           (stall),
                .i_clear_from_alu       (clear_alu),
                .i_condition_code       (cond_code),
                .i_destination_index    (dest_index),
                .i_alu_source           (alu_src),
                .i_shift_source         (shf_src),
                .i_alu_source_value     (alu_src_value),
                .i_shift_source_value   (shf_src_value),
                .i_shift_length_value   (shift_len),
                .i_shift_type           (shift_type),
                .i_disable_shifter      (disable_shifter),
                .i_force_align          (force_align),
                .i_pc_plus_8            (pc_plus_8),
                .i_carry                (carry),
                .i_carry_nxt            (carry_nxt),
                .i_alu_value_nxt        (alu_value_nxt),
                .i_alu_dav_nxt          (alu_dav_nxt),
                .o_condition_code       (dut_cc),
                .o_destination_index    (dut_dest),
                .o_alu_source_value     (dut_alu),
                .o_shifted_source_value (dut_shf),
                .o_shift_carry          (dut_carry),
                .o_pc_plus_8            (dut_pc8)
        );

        initial
        begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        //////////////////////////////////////////////////
        // Checks and stimulus.
        //////////////////////////////////////////////////

        task automatic check_value(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
                checks++;
                if (actv !== expv)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                                 $time, name, expv, actv);
                end
        endtask

        task automatic check_outputs();
                check_value("o_condition_code", 32'(exp_cc), 32'(dut_cc));
                check_value("o_destination_index", 32'(exp_dest), 32'(dut_dest));
                check_value("o_alu_source_value", exp_alu, dut_alu);
                check_value("o_shifted_source_value", exp_shf, dut_shf);
                check_value("o_shift_carry", 32'(exp_carry), 32'(dut_carry));
                check_value("o_pc_plus_8", exp_pc8, dut_pc8);
        endtask

        // Immediate, PC, the live destination (to hit forwarding) or any index.
        function automatic logic [32:0] pick_source();
                logic [1:0] sel;
                sel = 2'(lfsr_bits(2));
                case (sel)
                2'd0:    return {1'b1, lfsr_bits(32)};
                2'd1:    return 33'(PHY_PC);
                2'd2:    return 33'(exp_dest);
                default: return 33'(lfsr_bits(IDX_W) % PHY_REGS);
                endcase
        endfunction

        // Drives one cycle at the falling edge, then checks at the next one.
        task automatic step_cycle(input int mode);
                logic [32:0] a_word;
                logic [32:0] s_word;
                logic [32:0] shf;
                logic [31:0] alu_exp;
                logic [31:0] shf_exp;
                logic        carry_exp;
                a_word          = pick_source();
                s_word          = pick_source();
                alu_src         = a_word;
                shf_src         = s_word;
                cond_code       = 4'(lfsr_bits(4));
                dest_index      = IDX_W'(lfsr_bits(IDX_W) % PHY_REGS);
                alu_src_value   = lfsr_bits(32);
                shf_src_value   = lfsr_bits(32);
                shift_len       = lfsr_bits(24) << 8;
                shift_len[7:0]  = pick_amount();
                shift_type      = shift_op_t'(lfsr_bits(3) % 5);
                disable_shifter = (mode == MODE_SHIFT) ? 1'b0 :
                                  (mode == MODE_RESTORE) ? 1'b1 : lfsr_bits(1);
                force_align     = (mode == MODE_ALIGN) ? 1'b1 :
                                  (mode == MODE_CTRL) ? lfsr_bits(1) : 1'b0;
                pc_plus_8       = lfsr_bits(32);
                carry           = lfsr_bits(1);
                carry_nxt       = lfsr_bits(1);
                alu_value_nxt   = lfsr_bits(32);
                alu_dav_nxt     = lfsr_bits(1);
                clear_wb        = (mode == MODE_CTRL) && (lfsr_bits(2) == 0);
                stall           = (mode == MODE_CTRL) && (lfsr_bits(2) < 2);
                clear_alu       = (mode == MODE_CTRL) && lfsr_bits(1);

                alu_exp = resolve_ref(a_word, alu_src_value, pc_plus_8, exp_dest,
                                      alu_value_nxt, alu_dav_nxt);
                if (force_align)
                        alu_exp[1:0] = 2'b00;
                shf = shift_ref(shf_src_value, shift_len[7:0], shift_type, carry);
                shf_exp   = disable_shifter ? resolve_ref(s_word, shf_src_value, pc_plus_8,
                                exp_dest, alu_value_nxt, alu_dav_nxt) : shf[31:0];
                carry_exp = disable_shifter ? carry_nxt : shf[32];

                if (clear_wb)
                begin
                        exp_cc = COND_NV;
                end
                else if (!stall)
                begin
                        if (clear_alu)
                        begin
                                exp_cc = COND_NV;
                        end
                        else
                        begin
                                exp_cc    = cond_code;
                                exp_dest  = dest_index;
                                exp_alu   = alu_exp;
                                exp_shf   = shf_exp;
                                exp_carry = carry_exp;
                                exp_pc8   = pc_plus_8;
                        end
                end

                @(negedge clk);
                check_outputs();
        endtask

        task automatic run_test(input string name, input int mode, input int cycles);
                int err0;
                int chk0;
                err0 = errors;
                chk0 = checks;
                repeat (cycles) step_cycle(mode);
                tests++;
                $display("%-12s %0d checks, %0d errors", name, checks - chk0, errors - err0);
        endtask

        //////////////////////////////////////////////////
        // Main sequence.
        //////////////////////////////////////////////////

        initial
        begin
                lfsr_state      = 32'd59;
                checks          = 0;
                errors          = 0;
                tests           = 0;
                reset           = 1'b1;
                clear_wb        = 1'b0;
                stall           = 1'b0;
                clear_alu       = 1'b0;
                cond_code       = '0;
                dest_index      = '0;
                alu_src         = '0;
                shf_src         = '0;
                alu_src_value   = '0;
                shf_src_value   = '0;
                shift_len       = '0;
                shift_type      = LSL;
                disable_shifter = 1'b0;
                force_align     = 1'b0;
                pc_plus_8       = '0;
                carry           = 1'b0;
                carry_nxt       = 1'b0;
                alu_value_nxt   = '0;
                alu_dav_nxt     = 1'b0;
                exp_cc          = COND_NV;
                exp_dest        = '0;
                exp_alu         = '0;
                exp_shf         = '0;
                exp_carry       = 1'b0;
                exp_pc8         = '0;

                repeat (RESET_CYCLES) @(negedge clk);
                // Still in reset here, so the outputs hold their reset values.
                check_outputs();
                tests++;
                $display("%-12s %0d checks, %0d errors", "reset", checks, errors);
                reset = 1'b0;

                run_test("shifter", MODE_SHIFT, N_SHIFT);
                run_test("restore", MODE_RESTORE, N_RESTORE);
                run_test("alignment", MODE_ALIGN, N_ALIGN);
                run_test("clear_stall", MODE_CTRL, N_CTRL);

                $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
                if (errors == 0)
                begin
                        $display("test passed");
                end
                else
                begin
                        $display("test failed");
                end
                $finish;
        end

        initial
        begin
                #(TOTAL_CYCLES * 8 * 2);
                $display("Watchdog expired at %0t ns, the run did not complete", $time);
                $display("test failed");
                $finish;
        end

endmodule

//--- filelist.f
src/zap_shift_pkg.sv
src/zap_barrel_shifter.sv
src/zap_operand_resolver.sv
src/zap_shift_stage_regs.sv
src/zap_shift_stage.sv
+incdir+tests
tests/tb_shift_stage.sv
